//--- files.f
+incdir+common
common/img_pkt_pkg.sv
hdl/frame_ctrl.sv
pkt/header_inserter.sv
pkt/pkt_fifo.sv
pkt/tx_scheduler.sv
hdl/img_pkt_top.sv
dv/clk_rst_gen.sv
dv/img_pkt_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = img_pkt_tb
FILELIST  = files.f
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- dv/img_pkt_tb.sv
`include "img_pkt_config.svh"

module img_pkt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import img_pkt_pkg::*;

    localparam int LINES      = 2;                     // lines per frame
    localparam int LINE_WORDS = `IMG_LINE_BYTES / 4;
    localparam int NUM_CH     = `IMG_NUM_CHANNELS;
    localparam int MAX_DELAY  = 7;                     // sender stall cycles
    localparam int FRAME_CYC  = LINES * LINE_WORDS * 2 + LINES * (MAX_DELAY + 8) + 64;
    localparam int TIMEOUT    = 2 * ((NUM_CH + 1) * FRAME_CYC + 100);

    logic        eth_tx_clk;
    logic        rst_n;
    logic        single_req;
    logic        all_req;
    cam_bus_t    cam;
    ddr_bus_t    ddr;
    logic        ddr_frame_done;
    logic        udp_tx_req;
    logic        udp_tx_done;
    logic        gmii_tx_busy;
    udp_ctrl_t   udp;
    logic [31:0] udp_tx_data;
    logic        fifo_full;
    logic        frame_sent;
    logic        single_done;
    logic        all_done;

    logic [31:0] exp_q[$];      // expected word stream
    logic [31:0] rx_q[$];       // words read by the sender model
    logic [15:0] pkt_q[$];      // expected byte_num per packet
    logic [31:0] data_seed;
    logic [31:0] delay_seed;
    logic [31:0] got_word;
    logic [31:0] exp_word;
    int          err_data;
    int          err_pkt;
    int          err_ctrl;
    int          words_checked;
    int          sent_cnt;
    int          all_cnt;
    int          single_cnt;
    int          cycles;

    clk_rst_gen i_clk_rst_gen (
        .eth_tx_clk (eth_tx_clk),
        .rst_n      (rst_n)
    );

    img_pkt_top i_img_pkt_top (
        .eth_tx_clk     (eth_tx_clk),
        .rst_n          (rst_n),
        .single_req     (single_req),
        .all_req        (all_req),
        .cam            (cam),
        .ddr            (ddr),
        .ddr_frame_done (ddr_frame_done),
        .udp_tx_req     (udp_tx_req),
        .udp_tx_done    (udp_tx_done),
        .gmii_tx_busy   (gmii_tx_busy),
        .udp            (udp),
        .udp_tx_data    (udp_tx_data),
        .fifo_full      (fifo_full),
        .frame_sent     (frame_sent),
        .single_done    (single_done),
        .all_done       (all_done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected word idx of a frame, pix is the source word at that slot
    function automatic logic [31:0] ref_word(input xfer_mode_e m, input logic [3:0] ch,
                                             input int idx, input logic [31:0] pix);
        if (idx == 0) return `IMG_FRAME_HEAD;
        if (idx == 1) return {`IMG_H_PIXEL, `IMG_V_PIXEL};
        if (m == MODE_ALL && idx == 2) return {28'd0, ch};
        return pix;
    endfunction

    function automatic logic [15:0] pkt_bytes(input xfer_mode_e m, input bit first);
        if (!first) return `IMG_LINE_BYTES;
        return `IMG_LINE_BYTES + ((m == MODE_ALL) ? `IMG_HDR_ALL_BYTES : `IMG_HDR_SINGLE_BYTES);
    endfunction

    task automatic tick();
        @(posedge eth_tx_clk);
        #1;
    endtask

    // one sender cycle with busy held, no new start may be offered
    task automatic busy_tick();
        tick();
        assert (!udp.start_en) else begin
            err_pkt++;
            $display("[ERROR] %0t: start_en high while gmii_tx_busy", $time);
        end
    endtask

    // header words and packet sizes of one frame
    task automatic expect_frame(input xfer_mode_e m, input logic [3:0] ch);
        int hdr;
        hdr = (m == MODE_ALL) ? 3 : 2;
        for (int i = 0; i < hdr; i++) exp_q.push_back(ref_word(m, ch, i, 32'd0));
        for (int l = 0; l < LINES; l++) pkt_q.push_back(pkt_bytes(m, l == 0));
    endtask

    task automatic send_words(input xfer_mode_e m, input logic [3:0] ch);
        int hdr;
        hdr = (m == MODE_ALL) ? 3 : 2;
        for (int i = 0; i < LINES * LINE_WORDS; i++) begin
            data_seed = lcg_next(data_seed);
            exp_q.push_back(ref_word(m, ch, hdr + i, data_seed));
            if (m == MODE_ALL) begin
                ddr.data_en = 1'b1;
                ddr.data    = data_seed;
            end else begin
                cam.data_en = 1'b1;
                cam.data    = data_seed;
            end
            tick();
        end
        ddr.data_en = 1'b0;
        cam.data_en = 1'b0;
    endtask

    task automatic run_all_frame(input logic [3:0] ch);
        expect_frame(MODE_ALL, ch);
        ddr.frame_start = 1'b1;
        tick();
        ddr.frame_start = 1'b0;
        repeat (3) tick();           // head, resolution, channel slots
        send_words(MODE_ALL, ch);
        ddr_frame_done = 1'b1;
        tick();
        ddr_frame_done = 1'b0;
        while (sent_cnt < int'(ch) + 1) tick();
        repeat (2) tick();
    endtask

    task automatic run_single_frame();
        single_req = 1'b1;
        tick();
        single_req = 1'b0;
        repeat (2) tick();
        expect_frame(MODE_SINGLE, 4'd0);
        cam.vsync = 1'b1;
        repeat (4) tick();           // armed -> single after the rise
        all_req = 1'b1;              // not idle, must be ignored
        tick();
        all_req = 1'b0;
        cam.vsync = 1'b0;
        repeat (5) tick();
        send_words(MODE_SINGLE, 4'd0);
        while (exp_q.size() != 0 || gmii_tx_busy) tick();
        assert (single_cnt == 0) else begin
            err_ctrl++;
            $display("[ERROR] %0t: single_done before the closing vsync", $time);
        end
        cam.vsync = 1'b1;            // closing vsync
        while (single_cnt == 0) tick();
        cam.vsync = 1'b0;
        repeat (4) tick();
    endtask

    // ***********************************************************************
    // udp sender model
    // ***********************************************************************

    initial begin : sender
        logic [15:0] nbytes;
        logic [15:0] exp_bytes;
        int          dly;
        udp_tx_req   = 1'b0;
        udp_tx_done  = 1'b0;
        gmii_tx_busy = 1'b0;
        delay_seed   = lcg_next(32'd57);
        wait (rst_n);
        forever begin
            tick();
            if (udp.start_en) begin
                nbytes       = udp.byte_num;
                gmii_tx_busy = 1'b1;
                assert (pkt_q.size() > 0) else begin
                    err_pkt++;
                    $display("packet started at %0t with no packet expected", $time);
                end
                if (pkt_q.size() > 0) begin
                    exp_bytes = pkt_q.pop_front();
                    assert (nbytes == exp_bytes) else begin
                        err_pkt++;
                        $display("[ERROR] %0t: byte_num %0d expected %0d", $time,
                                 nbytes, exp_bytes);
                    end
                end
                delay_seed = lcg_next(delay_seed);
                dly        = int'(delay_seed[18:16]);   // busy stall
                repeat (dly) busy_tick();
                for (int i = 0; i < int'(nbytes) / 4; i++) begin
                    udp_tx_req = 1'b1;
                    busy_tick();
                    rx_q.push_back(udp_tx_data);
                end
                udp_tx_req  = 1'b0;
                udp_tx_done = 1'b1;
                busy_tick();
                udp_tx_done  = 1'b0;
                gmii_tx_busy = 1'b0;
            end
        end
    end

    // compare received words against the reference stream
    always @(negedge eth_tx_clk) begin
        while (rx_q.size() > 0) begin
            got_word = rx_q.pop_front();
            assert (exp_q.size() > 0) else begin
                err_data++;
                $display("word %h received at %0t with none expected", got_word, $time);
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                assert (got_word == exp_word) else begin
                    err_data++;
                    $display("[ERROR] %0t: word %0d got %h expected %h", $time,
                             words_checked, got_word, exp_word);
                end
                words_checked++;
            end
        end
    end

    // completion pulses and buffer level
    always @(negedge eth_tx_clk) begin
        if (rst_n) begin
            if (frame_sent) sent_cnt++;
            if (single_done) single_cnt++;
            if (all_done) begin
                all_cnt++;
                assert (sent_cnt == NUM_CH) else begin
                    err_ctrl++;
                    $display("[ERROR] %0t: all_done after %0d frames", $time, sent_cnt);
                end
            end
            // never more than one frame buffered, far below the depth
            assert (!fifo_full) else begin
                err_ctrl++;
                $display("[ERROR] %0t: fifo_full with at most one frame buffered", $time);
            end
        end
    end

    always @(posedge eth_tx_clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        single_req     = 1'b0;
        all_req        = 1'b0;
        cam            = '0;
        ddr            = '0;
        ddr_frame_done = 1'b0;
        data_seed      = 32'd57;
        err_data       = 0;
        err_pkt        = 0;
        err_ctrl       = 0;
        words_checked  = 0;
        sent_cnt       = 0;
        all_cnt        = 0;
        single_cnt     = 0;
        cycles         = 0;
        wait (rst_n);
        // idle after reset, nothing may start
        repeat (20) begin
            tick();
            assert (!udp.start_en && !frame_sent && !single_done && !all_done) else begin
                err_ctrl++;
                $display("[ERROR] %0t: output active with no request", $time);
            end
        end
        all_req = 1'b1;
        tick();
        all_req = 1'b0;
        repeat (2) tick();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (ch == 3) begin
                single_req = 1'b1;   // ignored in all mode
                tick();
                single_req = 1'b0;
            end
            run_all_frame(4'(ch));
        end
        repeat (4) tick();
        run_single_frame();
        repeat (10) tick();
        assert (sent_cnt == NUM_CH && all_cnt == 1 && single_cnt == 1) else begin
            err_ctrl++;
            $display("[ERROR] %0t: pulses frame_sent %0d all_done %0d single_done %0d",
                     $time, sent_cnt, all_cnt, single_cnt);
        end
        assert (exp_q.size() == 0 && pkt_q.size() == 0) else begin
            err_data++;
            $display("%0d words and %0d packets never arrived", exp_q.size(), pkt_q.size());
        end
        $display("errors: data %0d, packet %0d, control %0d (%0d words checked)",
                 err_data, err_pkt, err_ctrl, words_checked);
        if (err_data + err_pkt + err_ctrl == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- dv/clk_rst_gen.sv
module clk_rst_gen #(
    parameter int HALF_PERIOD = 4,    // 8 ns clock
    parameter int RST_CYCLES  = 3
) (
    output logic eth_tx_clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        eth_tx_clk = 1'b0;
        forever #(HALF_PERIOD) eth_tx_clk = ~eth_tx_clk;
    end

    // release just after an edge so no edge sees it change
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge eth_tx_clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- hdl/img_pkt_top.sv
`include "img_pkt_config.svh"

module img_pkt_top (
    input  logic                  eth_tx_clk,
    input  logic                  rst_n,
    input  logic                  single_req,
    input  logic                  all_req,
    input  img_pkt_pkg::cam_bus_t cam,
    input  img_pkt_pkg::ddr_bus_t ddr,
    input  logic                  ddr_frame_done,
    input  logic                  udp_tx_req,
    input  logic                  udp_tx_done,
    input  logic                  gmii_tx_busy,
    output img_pkt_pkg::udp_ctrl_t udp,
    output logic [31:0]           udp_tx_data,
    output logic                  fifo_full,
    output logic                  frame_sent,
    output logic                  single_done,
    output logic                  all_done
);
    import img_pkt_pkg::*;

    localparam int USED_W = $clog2(`IMG_FIFO_DEPTH) + 1;

    xfer_mode_e        mode;
    logic              frame_active;
    logic              fifo_clr;
    logic [3:0]        channel;
    logic              vsync_rise;
    logic              vsync_fall;
    fifo_wr_t          wr;
    logic [USED_W-1:0] fifo_used;
    logic              fifo_empty;
    logic              frame_start;

    // camera frames only count as a frame start in single mode
    assign frame_start = (vsync_fall && mode == MODE_SINGLE) || ddr.frame_start;

    frame_ctrl i_frame_ctrl (
        .eth_tx_clk      (eth_tx_clk),
        .rst_n           (rst_n),
        .single_req      (single_req),
        .all_req         (all_req),
        .vsync_rise      (vsync_rise),
        .ddr_frame_start (ddr.frame_start),
        .ddr_frame_done  (ddr_frame_done),
        .fifo_empty      (fifo_empty),
        .udp_tx_done     (udp_tx_done),
        .mode            (mode),
        .frame_active    (frame_active),
        .fifo_clr        (fifo_clr),
        .channel         (channel),
        .frame_sent      (frame_sent),
        .single_done     (single_done),
        .all_done        (all_done)
    );

    header_inserter i_header_inserter (
        .eth_tx_clk   (eth_tx_clk),
        .rst_n        (rst_n),
        .mode         (mode),
        .frame_active (frame_active),
        .cam          (cam),
        .ddr          (ddr),
        .channel      (channel),
        .vsync_rise   (vsync_rise),
        .vsync_fall   (vsync_fall),
        .wr           (wr)
    );

    pkt_fifo #(
        .DEPTH (`IMG_FIFO_DEPTH)
    ) i_pkt_fifo (
        .eth_tx_clk (eth_tx_clk),
        .rst_n      (rst_n),
        .clr        (fifo_clr),
        .wr         (wr),
        .rd_en      (udp_tx_req),
        .rd_data    (udp_tx_data),
        .used       (fifo_used),
        .empty      (fifo_empty),
        .full       (fifo_full)
    );

    tx_scheduler i_tx_scheduler (
        .eth_tx_clk   (eth_tx_clk),
        .rst_n        (rst_n),
        .mode         (mode),
        .frame_active (frame_active),
        .frame_start  (frame_start),
        .udp_tx_done  (udp_tx_done),
        .gmii_tx_busy (gmii_tx_busy),
        .fifo_used    (fifo_used),
        .udp          (udp)
    );

endmodule

//--- pkt/tx_scheduler.sv
`include "img_pkt_config.svh"

module tx_scheduler (
    input  logic                                eth_tx_clk,
    input  logic                                rst_n,
    input  img_pkt_pkg::xfer_mode_e             mode,
    input  logic                                frame_active,
    input  logic                                frame_start,
    input  logic                                udp_tx_done,
    input  logic                                gmii_tx_busy,
    input  logic [$clog2(`IMG_FIFO_DEPTH):0]    fifo_used,
    output img_pkt_pkg::udp_ctrl_t              udp
);
    import img_pkt_pkg::*;

    logic [15:0] hdr_bytes;
    logic [15:0] need_words;
    logic [15:0] have_words;
    logic        enough;

    // first packet of a frame also carries the header words
    assign hdr_bytes  = (mode == MODE_ALL) ? `IMG_HDR_ALL_BYTES : `IMG_HDR_SINGLE_BYTES;
    assign need_words = {2'b00, udp.byte_num[15:2]};
    assign have_words = 16'(fifo_used);
    assign enough     = (have_words >= need_words);

    // ***********************************************************************
    // packet byte count
    // ***********************************************************************

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            udp.byte_num <= 16'd0;
        end else if (frame_start) begin
            udp.byte_num <= `IMG_LINE_BYTES + hdr_bytes;
        end else if (udp_tx_done) begin
            udp.byte_num <= `IMG_LINE_BYTES;     // plain line from here on
        end
    end

    // start level, dropped while the mac is busy or the fifo is short
    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            udp.start_en <= 1'b0;
        end else begin
            udp.start_en <= frame_active && !gmii_tx_busy && enough;
        end
    end

endmodule

//--- pkt/pkt_fifo.sv
`include "img_pkt_config.svh"

module pkt_fifo #(
    parameter int DEPTH = `IMG_FIFO_DEPTH    // power of two
) (
    input  logic                   eth_tx_clk,
    input  logic                   rst_n,
    input  logic                   clr,
    input  img_pkt_pkg::fifo_wr_t  wr,
    input  logic                   rd_en,
    output logic [31:0]            rd_data,
    output logic [$clog2(DEPTH):0] used,
    output logic                   empty,
    output logic                   full
);
    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;
    logic [AW-1:0] wr_addr;

    assign empty   = (used == '0);
    assign full    = (used == (AW + 1)'(DEPTH));
    assign do_wr   = wr.en && (clr || !full);   // clear makes room
    assign do_rd   = rd_en && !empty && !clr;
    assign wr_addr = clr ? '0 : wr_ptr;

    // pointers and count
    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else if (clr) begin
            wr_ptr <= do_wr ? AW'(1) : '0;     // a coincident write lands first
            rd_ptr <= '0;
            used   <= do_wr ? (AW + 1)'(1) : '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            used <= used + (AW + 1)'(do_wr) - (AW + 1)'(do_rd);
        end
    end

    always_ff @(posedge eth_tx_clk) begin
        if (do_wr) mem[wr_addr] <= wr.data;
    end

    // registered read port
    always_ff @(posedge eth_tx_clk) begin
        if (do_rd) rd_data <= mem[rd_ptr];
    end

endmodule

//--- pkt/header_inserter.sv
`include "img_pkt_config.svh"

module header_inserter (
    input  logic                    eth_tx_clk,
    input  logic                    rst_n,
    input  img_pkt_pkg::xfer_mode_e mode,
    input  logic                    frame_active,
    input  img_pkt_pkg::cam_bus_t   cam,
    input  img_pkt_pkg::ddr_bus_t   ddr,
    input  logic [3:0]              channel,
    output logic                    vsync_rise,
    output logic                    vsync_fall,
    output img_pkt_pkg::fifo_wr_t   wr
);
    import img_pkt_pkg::*;

    logic        vsync_d0;
    logic        vsync_d1;
    logic        start_single;
    logic        start_all;
    logic [1:0]  hdr_dly;       // [0] resolution next, [1] channel next
    logic        src_en;
    logic [31:0] src_data;

    assign vsync_rise = vsync_d0 & ~vsync_d1;
    assign vsync_fall = ~vsync_d0 & vsync_d1;

    // frame begins after vsync in single mode, on frame_start from ddr
    assign start_single = (mode == MODE_SINGLE) && frame_active && vsync_fall;
    assign start_all    = (mode == MODE_ALL) && ddr.frame_start;

    assign src_en   = frame_active && ((mode == MODE_SINGLE) ? cam.data_en : ddr.data_en);
    assign src_data = (mode == MODE_SINGLE) ? cam.data : ddr.data;

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d0 <= 1'b0;
            vsync_d1 <= 1'b0;
            hdr_dly  <= 2'b00;
        end else begin
            vsync_d0   <= cam.vsync;
            vsync_d1   <= vsync_d0;
            hdr_dly[0] <= start_single | start_all;
            hdr_dly[1] <= hdr_dly[0] && (mode == MODE_ALL);  // only all mode has it
        end
    end

    // ***********************************************************************
    // fifo write port
    // ***********************************************************************

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr <= '0;
        end else if (start_single || start_all) begin
            wr.en   <= 1'b1;
            wr.data <= `IMG_FRAME_HEAD;
        end else if (hdr_dly[0]) begin
            wr.en   <= 1'b1;
            wr.data <= {`IMG_H_PIXEL, `IMG_V_PIXEL};
        end else if (hdr_dly[1]) begin
            wr.en   <= 1'b1;
            wr.data <= {28'd0, channel};
        end else if (src_en) begin
            wr.en   <= 1'b1;
            wr.data <= src_data;
        end else begin
            wr.en   <= 1'b0;
        end
    end

endmodule

//--- hdl/frame_ctrl.sv
`include "img_pkt_config.svh"

module frame_ctrl (
    input  logic                    eth_tx_clk,
    input  logic                    rst_n,
    input  logic                    single_req,
    input  logic                    all_req,
    input  logic                    vsync_rise,
    input  logic                    ddr_frame_start,
    input  logic                    ddr_frame_done,
    input  logic                    fifo_empty,
    input  logic                    udp_tx_done,
    output img_pkt_pkg::xfer_mode_e mode,
    output logic                    frame_active,
    output logic                    fifo_clr,
    output logic [3:0]              channel,
    output logic                    frame_sent,
    output logic                    single_done,
    output logic                    all_done
);
    import img_pkt_pkg::*;

    localparam logic [3:0] LAST_CH = 4'(`IMG_NUM_CHANNELS - 1);

    ctrl_state_e state;
    logic        pending;         // ddr finished, network not yet
    logic        frame_complete;
    logic        last_channel;

    // last packet of an all-mode frame has left the fifo
    assign frame_complete = (state == ST_ALL) && pending && fifo_empty && udp_tx_done;
    assign last_channel   = (channel == LAST_CH);

    // ***********************************************************************
    // FSM and mode
    // ***********************************************************************

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            mode  <= MODE_SINGLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (single_req) begin     // single wins if both arrive
                        state <= ST_ARMED;
                        mode  <= MODE_SINGLE;
                    end else if (all_req) begin
                        state <= ST_ALL;
                        mode  <= MODE_ALL;
                    end
                end
                ST_ARMED: begin
                    if (vsync_rise) state <= ST_SINGLE;
                end
                ST_SINGLE: begin
                    if (vsync_rise) state <= ST_IDLE;  // frame closed
                end
                ST_ALL: begin
                    if (frame_complete && last_channel) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame activity and buffer clear
    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_active <= 1'b0;
            fifo_clr     <= 1'b0;
        end else begin
            fifo_clr <= 1'b0;
            case (state)
                ST_ARMED: begin
                    if (vsync_rise) begin
                        fifo_clr     <= 1'b1;
                        frame_active <= 1'b1;
                    end
                end
                ST_SINGLE: begin
                    if (vsync_rise) frame_active <= 1'b0;
                end
                ST_ALL: begin
                    if (ddr_frame_start) begin
                        fifo_clr     <= 1'b1;
                        frame_active <= 1'b1;
                    end else if (frame_complete) begin
                        frame_active <= 1'b0;
                    end
                end
                default: frame_active <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (state != ST_ALL || frame_complete) begin
            pending <= 1'b0;
        end else if (ddr_frame_done) begin
            pending <= 1'b1;
        end
    end

    // ***********************************************************************
    // channel counter
    // ***********************************************************************

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            channel <= 4'd0;
        end else if (state == ST_IDLE && all_req && !single_req) begin
            channel <= 4'd0;                 // new all-frame run
        end else if (frame_complete && !last_channel) begin
            channel <= channel + 4'd1;
        end
    end

    // completion pulses, one cycle each
    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_sent  <= 1'b0;
            single_done <= 1'b0;
            all_done    <= 1'b0;
        end else begin
            frame_sent  <= frame_complete;
            single_done <= (state == ST_SINGLE) && vsync_rise;
            all_done    <= frame_complete && last_channel;
        end
    end

endmodule

//--- common/img_pkt_pkg.sv
package img_pkt_pkg;

    // which transfer the host asked for
    typedef enum logic {
        MODE_SINGLE = 1'b0,
        MODE_ALL    = 1'b1
    } xfer_mode_e;

    // frame control FSM
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ARMED  = 2'd1,    // waiting for the next vsync rise
        ST_SINGLE = 2'd2,    // one camera frame in flight
        ST_ALL    = 2'd3     // nine ddr frames in flight
    } ctrl_state_e;

    // camera side, synchronous to eth_tx_clk
    typedef struct packed {
        logic        vsync;
        logic        data_en;
        logic [31:0] data;
    } cam_bus_t;

    // ddr reader side
    typedef struct packed {
        logic        frame_start;  // one-cycle pulse ahead of each frame
        logic        data_en;
        logic [31:0] data;
    } ddr_bus_t;

    typedef struct packed {
        logic        en;
        logic [31:0] data;
    } fifo_wr_t;

    // towards the udp sender
    typedef struct packed {
        logic        start_en;
        logic [15:0] byte_num;
    } udp_ctrl_t;

endpackage

//--- common/img_pkt_config.svh
`ifndef IMG_PKT_CONFIG_SVH
`define IMG_PKT_CONFIG_SVH

// ***************************************************************************
// image geometry and frame markers
// ***************************************************************************

`define IMG_H_PIXEL          16'd1280       // upper half of resolution word
`define IMG_V_PIXEL          16'd800        // lower half of resolution word
`define IMG_FRAME_HEAD       32'hf05a_a50f  // first word of every frame

// ***************************************************************************
// packet sizing
// ***************************************************************************

`define IMG_LINE_BYTES       16'd1280       // one line per packet, 320 words
`define IMG_HDR_SINGLE_BYTES 16'd8          // head + resolution
`define IMG_HDR_ALL_BYTES    16'd12         // head + resolution + channel

// buffering and channel count
`define IMG_FIFO_DEPTH       2048
`define IMG_NUM_CHANNELS     9

`endif
